//--- Makefile
# Verilator flow for the VGA pixel path

VERILATOR  ?= verilator
FILELIST   ?= verilog.f
RTL_TOP    ?= vga_pixel_path_top
TB_TOP     ?= tb_vga_pixel_path
BUILD_DIR  ?= build
LOG        ?= sim.log
TIMESCALE  ?= 1ns/1ps
LINT_FLAGS ?= -Wall
SIM_FLAGS  ?= --binary --timing --assert

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --timescale $(TIMESCALE) $(LINT_FLAGS) \
		-f $(FILELIST) --top-module $(RTL_TOP)

build:
	$(VERILATOR) $(SIM_FLAGS) --timescale $(TIMESCALE) -f $(FILELIST) \
		--top-module $(TB_TOP) -Mdir $(BUILD_DIR)

# the log decides, not the exit code of the binary
sim: build
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	@if grep -q "^TEST PASS$$" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- dv/clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

// free running pixel clock for the testbench
module clk_gen (
    output logic clk_25_vga
);

    localparam int HALF_PERIOD_NS = 50;     // 100 ns period

    initial begin
        clk_25_vga = 1'b0;
    end

    always #HALF_PERIOD_NS clk_25_vga = ~clk_25_vga;

endmodule

`default_nettype wire

//--- dv/tb_vga_pixel_path.sv
`timescale 1ns/1ps
`default_nettype none

module tb_vga_pixel_path;

    // ==================================================
    // stimulus file layout
    // ==================================================
    localparam string STIM_FILE = "dv/vga_pixel_stimulus.txt";
    localparam int    FIELDS    = 10;               // hex words per line
    localparam int    MAX_WORDS = 4096;             // 12 bit word address
    localparam int    MAX_LINES = MAX_WORDS / FIELDS;
    localparam int    DRIVE_DLY = 10;               // after rising edge
    localparam int    CHECK_DLY = 80;               // 10 ns before next edge
    localparam int    RST_CYCLES = 5;

    logic                     clk_25_vga;
    logic                     arst_n;
    vga_pixel_pkg::rgb565_t   pix_in;
    logic                     active;
    logic                     vsync;
    vga_pixel_pkg::key_code_t key_code;
    logic                     key_valid;
    logic                     frame_ready;
    vga_pixel_pkg::channel_t  vga_r;
    vga_pixel_pkg::channel_t  vga_g;
    vga_pixel_pkg::channel_t  vga_b;

    logic [15:0] stim_mem [0:MAX_WORDS-1];
    logic        limit_ready = 1'b0;        // timeout armed once the file is read
    int          num_lines;
    int          line_idx;
    int          cur_test;
    int          test_checks;
    int          test_errors;
    int          check_count;
    int          error_count;
    int          tests_passed;
    int          tests_failed;
    int          cycle_count;
    int          timeout_cycles;

    clk_gen u_clk_gen (
        .clk_25_vga (clk_25_vga)
    );

    vga_pixel_path_top UUT (
        .clk_25_vga  (clk_25_vga),
        .arst_n      (arst_n),
        .pix_in      (pix_in),
        .active      (active),
        .vsync       (vsync),
        .key_code    (key_code),
        .key_valid   (key_valid),
        .frame_ready (frame_ready),
        .vga_r       (vga_r),
        .vga_g       (vga_g),
        .vga_b       (vga_b)
    );

    // ==================================================
    // helpers
    // ==================================================
    function automatic logic [15:0] stim_word(input int row, input int field);
        logic [11:0] addr;
        addr = 12'(row * FIELDS + field);
        return stim_mem[addr];
    endfunction

    function automatic string test_name(input int num);
        case (num)
            1:       return "blanking after reset";
            2:       return "enable timing";
            3:       return "original mode";
            4:       return "gray mode";
            5:       return "blanking outside active area and vsync";
            6:       return "disable";
            default: return "unnamed";
        endcase
    endfunction

    task automatic apply_line(input int row);
        logic [15:0] word;
        word = stim_word(row, 0);
        vsync = word[0];
        word = stim_word(row, 1);
        active = word[0];
        word = stim_word(row, 2);
        frame_ready = word[0];          // async level, changes off the edge anyway
        word = stim_word(row, 3);
        key_valid = word[0];
        word = stim_word(row, 4);
        key_code = word[7:0];
        pix_in = stim_word(row, 5);
    endtask

    task automatic check_channel(input string name, input logic [7:0] expected,
                                 input logic [7:0] actual);
        check_count++;
        test_checks++;
        assert (actual === expected) else begin
            $display("FAIL %s at line %0d (test %0d): expected %h, got %h",
                     name, line_idx, cur_test, expected, actual);
            error_count++;
            test_errors++;
        end
    endtask

    task automatic check_line(input int row);
        logic [15:0] exp_r;
        logic [15:0] exp_g;
        logic [15:0] exp_b;
        exp_r = stim_word(row, 7);
        exp_g = stim_word(row, 8);
        exp_b = stim_word(row, 9);
        check_channel("vga_r", exp_r[7:0], vga_r);
        check_channel("vga_g", exp_g[7:0], vga_g);
        check_channel("vga_b", exp_b[7:0], vga_b);
    endtask

    task automatic finish_test();
        if (test_errors == 0) begin
            tests_passed++;
            $display("test %0d %s: ok, %0d checks", cur_test, test_name(cur_test),
                     test_checks);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d of %0d checks wrong", cur_test,
                     test_name(cur_test), test_errors, test_checks);
        end
    endtask

    // ==================================================
    // main sequence
    // ==================================================
    initial begin : main
        int fill_idx;
        int row_test;
        arst_n       = 1'b0;
        vsync        = 1'b1;    // idle, sync inactive
        active       = 1'b0;
        frame_ready  = 1'b0;
        key_valid    = 1'b0;
        key_code     = '0;
        pix_in       = '0;
        cur_test     = 0;
        test_checks  = 0;
        test_errors  = 0;
        check_count  = 0;
        error_count  = 0;
        tests_passed = 0;
        tests_failed = 0;

        // untouched words keep f in the top nibble and their own address below
        for (fill_idx = 0; fill_idx < MAX_WORDS; fill_idx++) begin
            stim_mem[12'(fill_idx)] = {4'hF, 12'(fill_idx)};
        end
        $readmemh(STIM_FILE, stim_mem);
        num_lines = 0;
        while (num_lines < MAX_LINES &&
               stim_word(num_lines, 0) !== {4'hF, 12'(num_lines * FIELDS)}) begin
            num_lines++;
        end
        timeout_cycles = 2 * num_lines + 20;
        limit_ready    = 1'b1;

        repeat (RST_CYCLES) @(posedge clk_25_vga);
        #DRIVE_DLY;
        arst_n = 1'b1;

        for (line_idx = 0; line_idx < num_lines; line_idx++) begin
            @(posedge clk_25_vga);
            #DRIVE_DLY;
            apply_line(line_idx);
            #CHECK_DLY;                 // outputs settled from this edge
            row_test = int'(stim_word(line_idx, 6));
            if (row_test != 0) begin
                if (row_test != cur_test) begin
                    if (cur_test != 0) begin
                        finish_test();
                    end
                    cur_test    = row_test;
                    test_checks = 0;
                    test_errors = 0;
                end
                check_line(line_idx);
            end
        end
        if (cur_test != 0) begin
            finish_test();
        end

        if (num_lines == 0) begin
            $display("no stimulus lines could be read from %s", STIM_FILE);
        end
        $display("tests passed %0d, failed %0d, checks %0d, errors %0d",
                 tests_passed, tests_failed, check_count, error_count);
        if (error_count == 0 && num_lines > 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // ==================================================
    // watchdog
    // ==================================================
    initial begin : watchdog
        cycle_count = 0;
        wait (limit_ready);
        while (cycle_count < timeout_cycles) begin
            @(posedge clk_25_vga);
            cycle_count++;
        end
        $display("timeout: the run did not finish within %0d clock cycles", timeout_cycles);
        $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- dv/vga_pixel_stimulus.txt
// vsync active frame_ready key_valid key_code pix_in test exp_r exp_g exp_b, all hex
// one line per clock; test 0 skips the compare, expected rgb is for this same clock
1 0 0 0 00 0000 1 00 00 00
1 0 0 0 00 0000 1 00 00 00
1 1 0 0 00 F800 1 00 00 00
1 1 0 0 00 07E0 1 00 00 00
1 1 0 0 00 001F 1 00 00 00
1 1 0 0 00 FFFF 1 00 00 00
1 0 0 0 00 0000 1 00 00 00
1 0 0 0 00 0000 1 00 00 00
0 0 0 0 00 0000 1 00 00 00
0 0 0 0 00 0000 1 00 00 00
1 1 0 0 00 FFFF 2 00 00 00
1 1 1 0 00 F800 2 00 00 00
1 1 1 0 00 07E0 2 00 00 00
1 1 1 0 00 001F 2 00 00 00
1 1 1 0 00 8410 2 00 00 00
1 0 1 0 00 0000 2 00 00 00
0 0 1 0 00 0000 2 00 00 00
0 0 1 0 00 0000 2 00 00 00
1 1 1 0 00 F800 2 00 00 00
1 1 1 0 00 07E0 2 00 00 00
1 1 1 0 00 001F 2 00 00 00
1 1 1 0 00 0000 2 FF 03 07
1 1 1 0 00 8410 3 07 FF 07
1 0 1 0 00 0000 3 07 03 FF
1 0 1 0 00 0000 3 07 03 07
1 0 1 0 00 0000 3 87 83 87
1 0 1 1 0F 0000 4 00 00 00
1 1 1 0 00 F800 4 00 00 00
1 1 1 0 00 07E0 4 00 00 00
1 1 1 0 00 001F 4 00 00 00
1 1 1 0 00 FFFF 4 4E 4E 4E
1 1 1 1 55 0000 4 98 98 98
1 1 1 0 00 8410 4 1D 1D 1D
1 0 1 1 12 0000 4 FB FB FB
1 1 1 0 00 F800 4 04 04 04
1 0 1 0 00 0000 4 82 82 82
1 0 1 0 00 0000 4 00 00 00
1 0 1 0 00 0000 4 FF 03 07
1 1 1 0 00 FFFF 5 00 00 00
1 0 1 0 00 FFFF 5 00 00 00
1 1 1 0 00 07E0 5 00 00 00
0 1 1 0 00 FFFF 5 FF FF FF
0 1 1 0 00 FFFF 5 00 00 00
1 1 1 0 00 001F 5 00 00 00
1 1 1 0 00 F800 5 00 00 00
1 1 1 0 00 0000 5 00 00 00
1 1 1 0 00 FFFF 5 07 03 FF
1 1 1 0 00 8410 5 FF 03 07
1 1 0 0 00 F800 5 07 03 07
1 1 0 0 00 07E0 6 FF FF FF
1 1 0 0 00 001F 6 87 83 87
1 1 0 0 00 FFFF 6 FF 03 07
1 1 0 0 00 FFFF 6 00 00 00
1 0 0 0 00 0000 6 00 00 00
1 0 0 0 00 0000 6 00 00 00
1 0 0 0 00 0000 6 00 00 00
0 0 0 0 00 0000 6 00 00 00
0 0 0 0 00 0000 6 00 00 00
1 1 0 0 00 FFFF 6 00 00 00
1 1 0 0 00 FFFF 6 00 00 00
1 0 0 0 00 0000 6 00 00 00
1 0 0 0 00 0000 6 00 00 00
1 0 0 0 00 0000 6 00 00 00

//--- hw/display_enable.sv
`timescale 1ns/1ps
`default_nettype none

module display_enable (
    input  wire  clk_25_vga,
    input  wire  arst_n,
    input  wire  frame_ready,   // async level from the capture side
    input  wire  vsync,         // active low
    output logic disp_en
);

    // ==================================================
    // frame_ready synchronizer
    // ==================================================
    logic [vga_pixel_pkg::SYNC_STAGES-1:0] ready_sync;
    logic                                  ready_s;    // last sync stage

    always_ff @(posedge clk_25_vga or negedge arst_n) begin
        if (!arst_n) begin
            ready_sync <= '0;
        end else begin
            // shift in at bit 0
            ready_sync <= {ready_sync[vga_pixel_pkg::SYNC_STAGES-2:0], frame_ready};
        end
    end

    assign ready_s = ready_sync[vga_pixel_pkg::SYNC_STAGES-1];

    // ==================================================
    // vsync edge and enable
    // ==================================================
    logic vsync_q;
    logic vsync_rise;   // end of sync pulse, start of a frame

    assign vsync_rise = vsync & ~vsync_q;

    always_ff @(posedge clk_25_vga or negedge arst_n) begin
        if (!arst_n) begin
            vsync_q <= 1'b1;        // idle high, no false edge out of reset
            disp_en <= 1'b0;
        end else begin
            vsync_q <= vsync;
            if (!ready_s) begin
                disp_en <= 1'b0;    // camera gone, blank at once
            end else if (vsync_rise) begin
                disp_en <= 1'b1;    // whole frame from here on
            end
        end
    end

    // ==================================================
    // checks
    // ==================================================
    // a rise of disp_en follows a low-to-high step seen on the vsync input
    en_on_vsync_rise_a : assert property (
        @(posedge clk_25_vga) disable iff (!arst_n)
        $rose(disp_en) |-> ($past(vsync, 1) && !$past(vsync, 2))
    );

endmodule

`default_nettype wire

//--- hw/ir_mode_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module ir_mode_decoder (
    input  wire                          clk_25_vga,
    input  wire                          arst_n,
    input  wire vga_pixel_pkg::key_code_t key_code,   // from ir receiver
    input  wire                          key_valid,  // one-cycle strobe
    output vga_pixel_pkg::disp_mode_t    mode
);

    // ==================================================
    // mode register
    // ==================================================
    vga_pixel_pkg::disp_mode_t mode_q;
    vga_pixel_pkg::disp_mode_t mode_nxt;

    // decode only the two keys we care about
    always_comb begin
        mode_nxt = mode_q;
        if (key_valid) begin
            case (key_code)
                vga_pixel_pkg::KEY_ORIG: mode_nxt = vga_pixel_pkg::MODE_ORIG;
                vga_pixel_pkg::KEY_GRAY: mode_nxt = vga_pixel_pkg::MODE_GRAY;
                default:                 mode_nxt = mode_q; // unknown key, keep mode
            endcase
        end
    end

    always_ff @(posedge clk_25_vga or negedge arst_n) begin
        if (!arst_n) begin
            mode_q <= vga_pixel_pkg::MODE_ORIG;     // colour after reset
        end else begin
            mode_q <= mode_nxt;
        end
    end

    assign mode = mode_q;

    // ==================================================
    // checks
    // ==================================================
    // mode stays a legal value, and only moves the clock after a strobe
    mode_legal_a : assert property (
        @(posedge clk_25_vga) disable iff (!arst_n)
        !$isunknown(mode_q) &&
        (mode_q inside {vga_pixel_pkg::MODE_ORIG, vga_pixel_pkg::MODE_GRAY})
    );

    mode_after_strobe_a : assert property (
        @(posedge clk_25_vga) disable iff (!arst_n)
        (mode_q != $past(mode_q)) |-> $past(key_valid)
    );

endmodule

`default_nettype wire

//--- hw/rgb565_unpack.sv
`timescale 1ns/1ps
`default_nettype none

module rgb565_unpack (
    input  wire                          clk_25_vga,
    input  wire                          arst_n,
    input  wire                          vsync,      // active low
    input  wire vga_pixel_pkg::rgb565_t  pix_in,
    input  wire                          active,
    output vga_pixel_pkg::channel_t      red,
    output vga_pixel_pkg::channel_t      green,
    output vga_pixel_pkg::channel_t      blue,
    output vga_pixel_pkg::channel_t      gray,
    output logic                         active_q    // active, one clock late
);

    // ==================================================
    // rgb565 -> rgb888, low bits padded with ones
    // ==================================================
    vga_pixel_pkg::channel_t  r8;
    vga_pixel_pkg::channel_t  g8;
    vga_pixel_pkg::channel_t  b8;
    vga_pixel_pkg::gray_sum_t gray_sum;

    assign r8 = {pix_in[15:11], 3'b111};   // 5 -> 8
    assign g8 = {pix_in[10:5], 2'b11};     // 6 -> 8
    assign b8 = {pix_in[4:0], 3'b111};     // 5 -> 8

    // 76r + 150g + 26b, top byte is the gray level
    assign gray_sum = 16'(r8) * 16'(vga_pixel_pkg::GRAY_W_R)
                    + 16'(g8) * 16'(vga_pixel_pkg::GRAY_W_G)
                    + 16'(b8) * 16'(vga_pixel_pkg::GRAY_W_B);

    // ==================================================
    // output register
    // ==================================================
    always_ff @(posedge clk_25_vga or negedge arst_n) begin
        if (!arst_n) begin
            red      <= '0;
            green    <= '0;
            blue     <= '0;
            gray     <= '0;
            active_q <= 1'b0;
        end else if (!vsync) begin
            // frame sync, flush the stage
            red      <= '0;
            green    <= '0;
            blue     <= '0;
            gray     <= '0;
            active_q <= 1'b0;
        end else if (active) begin
            red      <= r8;
            green    <= g8;
            blue     <= b8;
            gray     <= gray_sum[15:8];
            active_q <= 1'b1;
        end else begin
            red      <= '0;     // porch / blanking
            green    <= '0;
            blue     <= '0;
            gray     <= '0;
            active_q <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- hw/vga_pixel_path_top.sv
`timescale 1ns/1ps
`default_nettype none

module vga_pixel_path_top (
    input  wire                           clk_25_vga,
    input  wire                           arst_n,
    input  wire vga_pixel_pkg::rgb565_t   pix_in,      // frame buffer read data
    input  wire                           active,      // vga visible area
    input  wire                           vsync,       // active low
    input  wire vga_pixel_pkg::key_code_t key_code,
    input  wire                           key_valid,
    input  wire                           frame_ready, // async, from capture
    output vga_pixel_pkg::channel_t       vga_r,
    output vga_pixel_pkg::channel_t       vga_g,
    output vga_pixel_pkg::channel_t       vga_b
);

    // ==================================================
    // internal nets
    // ==================================================
    vga_pixel_pkg::disp_mode_t mode;
    vga_pixel_pkg::channel_t   red;
    vga_pixel_pkg::channel_t   green;
    vga_pixel_pkg::channel_t   blue;
    vga_pixel_pkg::channel_t   gray;
    logic                      active_q;
    logic                      disp_en;

    // remote key -> display mode
    ir_mode_decoder u_ir_mode_decoder (
        .clk_25_vga (clk_25_vga),
        .arst_n     (arst_n),
        .key_code   (key_code),
        .key_valid  (key_valid),
        .mode       (mode)
    );

    // stage 1, colour expand + luma
    rgb565_unpack u_rgb565_unpack (
        .clk_25_vga (clk_25_vga),
        .arst_n     (arst_n),
        .vsync      (vsync),
        .pix_in     (pix_in),
        .active     (active),
        .red        (red),
        .green      (green),
        .blue       (blue),
        .gray       (gray),
        .active_q   (active_q)
    );

    // first-frame gate
    display_enable u_display_enable (
        .clk_25_vga  (clk_25_vga),
        .arst_n      (arst_n),
        .frame_ready (frame_ready),
        .vsync       (vsync),
        .disp_en     (disp_en)
    );

    // stages 2 and 3
    video_mux u_video_mux (
        .clk_25_vga (clk_25_vga),
        .arst_n     (arst_n),
        .vsync      (vsync),
        .mode       (mode),
        .disp_en    (disp_en),
        .red        (red),
        .green      (green),
        .blue       (blue),
        .gray       (gray),
        .active_q   (active_q),
        .vga_r      (vga_r),
        .vga_g      (vga_g),
        .vga_b      (vga_b)
    );

endmodule

`default_nettype wire

//--- hw/vga_pixel_pkg.sv
`default_nettype none

package vga_pixel_pkg;

    // ==================================================
    // widths with a meaning
    // ==================================================
    typedef logic [15:0] rgb565_t;      // frame buffer word, r5 g6 b5
    typedef logic [7:0]  channel_t;     // one colour or gray channel
    typedef logic [7:0]  key_code_t;    // ir remote key
    typedef logic [15:0] gray_sum_t;    // weighted sum, max 255*252 fits

    // display modes
    typedef enum logic {
        MODE_ORIG = 1'b0,               // pass colour through
        MODE_GRAY = 1'b1                // gray on all three channels
    } disp_mode_t;

    // ==================================================
    // constants
    // ==================================================
    localparam key_code_t KEY_ORIG = 8'h12;   // 'ok' key
    localparam key_code_t KEY_GRAY = 8'h0F;   // 'a' key

    // luma weights, sum is 252 so gray tops out just under ff
    localparam logic [7:0] GRAY_W_R = 8'd76;
    localparam logic [7:0] GRAY_W_G = 8'd150;
    localparam logic [7:0] GRAY_W_B = 8'd26;

    localparam int PIXEL_LAT   = 3;     // pix_in -> vga_rgb, in clocks
    localparam int SYNC_STAGES = 2;     // frame_ready cdc depth

endpackage

`default_nettype wire

//--- hw/video_mux.sv
`timescale 1ns/1ps
`default_nettype none

module video_mux (
    input  wire                             clk_25_vga,
    input  wire                             arst_n,
    input  wire                             vsync,      // active low
    input  wire vga_pixel_pkg::disp_mode_t  mode,
    input  wire                             disp_en,
    input  wire vga_pixel_pkg::channel_t    red,
    input  wire vga_pixel_pkg::channel_t    green,
    input  wire vga_pixel_pkg::channel_t    blue,
    input  wire vga_pixel_pkg::channel_t    gray,
    input  wire                             active_q,
    output vga_pixel_pkg::channel_t         vga_r,
    output vga_pixel_pkg::channel_t         vga_g,
    output vga_pixel_pkg::channel_t         vga_b
);

    // ==================================================
    // alignment stage
    // ==================================================
    vga_pixel_pkg::channel_t   red_d;
    vga_pixel_pkg::channel_t   green_d;
    vga_pixel_pkg::channel_t   blue_d;
    vga_pixel_pkg::channel_t   gray_d;
    vga_pixel_pkg::disp_mode_t mode_d;     // mode seen when the pixel came in
    logic                      active_d;
    logic                      show;

    always_ff @(posedge clk_25_vga or negedge arst_n) begin
        if (!arst_n) begin
            red_d    <= '0;
            green_d  <= '0;
            blue_d   <= '0;
            gray_d   <= '0;
            mode_d   <= vga_pixel_pkg::MODE_ORIG;
            active_d <= 1'b0;
        end else if (!vsync) begin
            // frame sync, flush the stage
            red_d    <= '0;
            green_d  <= '0;
            blue_d   <= '0;
            gray_d   <= '0;
            mode_d   <= vga_pixel_pkg::MODE_ORIG;
            active_d <= 1'b0;
        end else begin
            red_d    <= red;
            green_d  <= green;
            blue_d   <= blue;
            gray_d   <= gray;
            mode_d   <= mode;
            active_d <= active_q;
        end
    end

    // ==================================================
    // select and output register
    // ==================================================
    assign show = disp_en & active_d;     // blank unless enabled and visible

    always_ff @(posedge clk_25_vga or negedge arst_n) begin
        if (!arst_n) begin
            vga_r <= '0;
            vga_g <= '0;
            vga_b <= '0;
        end else if (!vsync || !show) begin
            vga_r <= '0;
            vga_g <= '0;
            vga_b <= '0;
        end else if (mode_d == vga_pixel_pkg::MODE_GRAY) begin
            vga_r <= gray_d;    // same level on all guns
            vga_g <= gray_d;
            vga_b <= gray_d;
        end else begin
            vga_r <= red_d;
            vga_g <= green_d;
            vga_b <= blue_d;
        end
    end

    // black on the clock after an invisible aligned pixel
    blank_when_inactive_a : assert property (
        @(posedge clk_25_vga) disable iff (!arst_n)
        !active_d |=> (vga_r == '0) && (vga_g == '0) && (vga_b == '0)
    );

endmodule

`default_nettype wire

//--- verilog.f
hw/vga_pixel_pkg.sv
hw/ir_mode_decoder.sv
hw/rgb565_unpack.sv
hw/display_enable.sv
hw/video_mux.sv
hw/vga_pixel_path_top.sv
dv/clk_gen.sv
dv/tb_vga_pixel_path.sv
